// File: source/uart_pkg.sv
package uart_pkg;

   // one data byte as it travels on the serial line
   typedef logic [7:0] byte_t;

   // receiver output, payload plus stop-bit check result
   typedef struct packed {
      byte_t data;
      logic  frame_err;
   } rx_word_t;

   // transmitter credit count, wide enough for TX_CREDITS
   typedef logic [1:0] credit_t;

   // holding register plus shift register in uart_tx
   localparam int TX_CREDITS = 2;

   typedef enum logic [1:0] {
      RX_IDLE,
      RX_START,
      RX_DATA,
      RX_STOP
   } rx_state_t;

   typedef enum logic [1:0] {
      TX_IDLE,
      TX_START,
      TX_DATA,
      TX_STOP
   } tx_state_t;

endpackage

// File: source/uart_rx.sv
`timescale 1ns/1ps

module uart_rx
   import uart_pkg::*;
#(
   parameter int CLKS_PER_BIT = 8
) (
   input  logic     clk,
   input  logic     rst_n,
   input  logic     rx,
   output rx_word_t rx_word,
   output logic     rx_valid
);

   localparam int CNT_W = $clog2(CLKS_PER_BIT);
   localparam int HALF_BIT = CLKS_PER_BIT / 2;

   logic             rx_meta;
   logic             rx_sync;
   logic             rx_prev;
   rx_state_t        state;
   logic [CNT_W-1:0] clk_cnt;
   logic [2:0]       bit_cnt;
   byte_t            shift_reg;
   logic             bit_end;

   // line idles high, so the synchronizer resets to 1
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
         rx_prev <= 1'b1;
      end else begin
         rx_meta <= rx;
         rx_sync <= rx_meta;
         rx_prev <= rx_sync;
      end
   end

   assign bit_end = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state    <= RX_IDLE;
         clk_cnt  <= '0;
         bit_cnt  <= '0;
         rx_valid <= 1'b0;
      end else begin
         rx_valid <= 1'b0;
         case (state)
            RX_IDLE: begin
               // edge, not level, so a low stop bit cannot retrigger
               if (rx_prev && !rx_sync) begin
                  state   <= RX_START;
                  clk_cnt <= '0;
               end
            end
            RX_START: begin
               if (clk_cnt == CNT_W'(HALF_BIT - 1)) begin
                  clk_cnt <= '0;
                  bit_cnt <= '0;
                  // glitch shorter than half a bit is ignored
                  state   <= rx_sync ? RX_IDLE : RX_DATA;
               end else begin
                  clk_cnt <= clk_cnt + 1'b1;
               end
            end
            RX_DATA: begin
               if (bit_end) begin
                  clk_cnt <= '0;
                  bit_cnt <= bit_cnt + 1'b1;
                  if (bit_cnt == 3'd7) begin
                     state <= RX_STOP;
                  end
               end else begin
                  clk_cnt <= clk_cnt + 1'b1;
               end
            end
            RX_STOP: begin
               if (bit_end) begin
                  clk_cnt  <= '0;
                  rx_valid <= 1'b1;
                  state    <= RX_IDLE;
               end else begin
                  clk_cnt <= clk_cnt + 1'b1;
               end
            end
            default: state <= RX_IDLE;
         endcase
      end
   end

   // lsb arrives first, shifted in from the top
   always_ff @(posedge clk) begin
      if (state == RX_DATA && bit_end) begin
         shift_reg <= {rx_sync, shift_reg[7:1]};
      end
      if (state == RX_STOP && bit_end) begin
         rx_word.data      <= shift_reg;
         rx_word.frame_err <= !rx_sync;
      end
   end

   a_rx_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      rx_valid |=> !rx_valid);

endmodule

// File: source/echo_buffer.sv
`timescale 1ns/1ps

module echo_buffer
   import uart_pkg::*;
#(
   parameter int FIFO_DEPTH = 4
) (
   input  logic     clk,
   input  logic     rst_n,
   input  rx_word_t rx_word,
   input  logic     rx_valid,
   output byte_t    tx_data,
   output logic     tx_valid,
   input  logic     credit_return,
   output logic     overrun,
   output logic     frame_error
);

   localparam int PTR_W = $clog2(FIFO_DEPTH);

   byte_t            mem [FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W:0]   count;
   credit_t          credits;
   logic             full;
   logic             empty;
   logic             push;

   assign full  = (count == (PTR_W + 1)'(FIFO_DEPTH));
   assign empty = (count == '0);

   // only good words that find room are stored
   assign push = rx_valid && !rx_word.frame_err && !full;

   // release the head whenever the transmitter has room
   assign tx_valid = !empty && (credits != '0);
   assign tx_data  = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= rx_word.data;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (tx_valid) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         if (push && !tx_valid) begin
            count <= count + 1'b1;
         end else if (!push && tx_valid) begin
            count <= count - 1'b1;
         end
      end
   end

   // use and return in the same cycle cancel out
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         credits <= credit_t'(TX_CREDITS);
      end else if (tx_valid && !credit_return) begin
         credits <= credits - 1'b1;
      end else if (!tx_valid && credit_return) begin
         credits <= credits + 1'b1;
      end
   end

   // sticky until reset
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         overrun     <= 1'b0;
         frame_error <= 1'b0;
      end else if (rx_valid) begin
         if (rx_word.frame_err) begin
            frame_error <= 1'b1;
         end else if (full) begin
            overrun <= 1'b1;
         end
      end
   end

   a_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
      credits <= credit_t'(TX_CREDITS));

endmodule

// File: source/uart_tx.sv
`timescale 1ns/1ps

module uart_tx
   import uart_pkg::*;
#(
   parameter int CLKS_PER_BIT = 8,
   parameter int TX_STOP_BITS = 1
) (
   input  logic  clk,
   input  logic  rst_n,
   input  byte_t tx_data,
   input  logic  tx_valid,
   output logic  tx,
   output logic  credit_return
);

   localparam int CNT_W = $clog2(CLKS_PER_BIT);

   tx_state_t        state;
   logic [CNT_W-1:0] clk_cnt;
   logic [2:0]       bit_cnt;
   logic             stop_idx;
   byte_t            shift_reg;
   byte_t            hold_reg;
   logic             hold_full;
   logic             bit_end;
   logic             frame_done;

   assign bit_end    = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));
   assign frame_done = (state == TX_STOP) && bit_end && (stop_idx == 1'(TX_STOP_BITS - 1));

   // frees the shift register, hold byte moves in on the same edge
   assign credit_return = frame_done;

   always_comb begin
      case (state)
         TX_START: tx = 1'b0;
         TX_DATA:  tx = shift_reg[0];
         default:  tx = 1'b1;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state     <= TX_IDLE;
         clk_cnt   <= '0;
         bit_cnt   <= '0;
         stop_idx  <= 1'b0;
         hold_full <= 1'b0;
      end else begin
         if (state == TX_IDLE || frame_done) begin
            clk_cnt  <= '0;
            bit_cnt  <= '0;
            stop_idx <= 1'b0;
            if (hold_full) begin
               shift_reg <= hold_reg;
               hold_full <= 1'b0;
               state     <= TX_START;
            end else if (tx_valid) begin
               shift_reg <= tx_data;
               state     <= TX_START;
            end else begin
               state <= TX_IDLE;
            end
         end else begin
            // byte arriving mid-frame waits in the holding register
            if (tx_valid) begin
               hold_reg  <= tx_data;
               hold_full <= 1'b1;
            end
            clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
            if (bit_end) begin
               case (state)
                  TX_START: state <= TX_DATA;
                  TX_DATA: begin
                     shift_reg <= shift_reg >> 1;
                     bit_cnt   <= bit_cnt + 1'b1;
                     if (bit_cnt == 3'd7) begin
                        state <= TX_STOP;
                     end
                  end
                  default: stop_idx <= stop_idx + 1'b1;
               endcase
            end
         end
      end
   end

   a_hold_free: assert property (@(posedge clk) disable iff (!rst_n)
      tx_valid |-> !hold_full);

endmodule

// File: source/uart_echo_top.sv
`timescale 1ns/1ps

module uart_echo_top
   import uart_pkg::*;
#(
   parameter int CLKS_PER_BIT = 8,
   parameter int TX_STOP_BITS = 1,
   parameter int FIFO_DEPTH   = 4
) (
   input  logic clk,
   input  logic rst_n,
   input  logic rx,
   output logic tx,
   output logic overrun,
   output logic frame_error
);

   rx_word_t rx_word;
   logic     rx_valid;
   byte_t    tx_data;
   logic     tx_valid;
   logic     credit_return;

   uart_rx #(
      .CLKS_PER_BIT(CLKS_PER_BIT)
   ) u_rx (
      .clk     (clk),
      .rst_n   (rst_n),
      .rx      (rx),
      .rx_word (rx_word),
      .rx_valid(rx_valid)
   );

   echo_buffer #(
      .FIFO_DEPTH(FIFO_DEPTH)
   ) u_buffer (
      .clk          (clk),
      .rst_n        (rst_n),
      .rx_word      (rx_word),
      .rx_valid     (rx_valid),
      .tx_data      (tx_data),
      .tx_valid     (tx_valid),
      .credit_return(credit_return),
      .overrun      (overrun),
      .frame_error  (frame_error)
   );

   uart_tx #(
      .CLKS_PER_BIT(CLKS_PER_BIT),
      .TX_STOP_BITS(TX_STOP_BITS)
   ) u_tx (
      .clk          (clk),
      .rst_n        (rst_n),
      .tx_data      (tx_data),
      .tx_valid     (tx_valid),
      .tx           (tx),
      .credit_return(credit_return)
   );

endmodule

// File: testbench/serial_host.sv
`timescale 1ns/1ps

module serial_host
   import uart_pkg::*;
#(
   parameter int CLKS_PER_BIT = 8
) (
   input  logic clk,
   input  logic tx,
   output logic rx
);

   initial begin
      rx = 1'b1;
   end

   // each step lands 1 ns after a rising edge
   task automatic wait_clocks(input int n);
      repeat (n) begin
         @(posedge clk);
         #1;
      end
   endtask

   // one frame with a single stop bit of the given value, then idle bits
   task automatic send_byte(input byte_t data, input logic stop_val, input int idle_bits);
      int i;
      rx = 1'b0;
      wait_clocks(CLKS_PER_BIT);
      for (i = 0; i < 8; i++) begin
         rx = data[i];
         wait_clocks(CLKS_PER_BIT);
      end
      rx = stop_val;
      wait_clocks(CLKS_PER_BIT);
      rx = 1'b1;
      wait_clocks(idle_bits * CLKS_PER_BIT);
   endtask

   // waits for a falling edge on tx, gives up after max_idle quiet cycles
   task automatic receive_byte(output byte_t data, output logic start_val,
                               output logic stop_val, output logic got,
                               input int max_idle);
      int idle;
      int i;
      got       = 1'b0;
      idle      = 0;
      data      = '0;
      start_val = 1'b1;
      stop_val  = 1'b1;
      while (tx !== 1'b0 && idle < max_idle) begin
         wait_clocks(1);
         idle++;
      end
      if (tx === 1'b0) begin
         got = 1'b1;
         // midpoint of the start bit
         wait_clocks(CLKS_PER_BIT / 2);
         start_val = tx;
         for (i = 0; i < 8; i++) begin
            wait_clocks(CLKS_PER_BIT);
            data[i] = tx;
         end
         wait_clocks(CLKS_PER_BIT);
         stop_val = tx;
      end
   endtask

endmodule

// File: testbench/tb_uart_echo.sv
`timescale 1ns/1ps

module tb_uart_echo
   import uart_pkg::*;
#(
   parameter int TX_STOP_BITS = 1
) ();

   localparam int CLKS_PER_BIT = 8;
   localparam int FIFO_DEPTH   = 4;
   localparam int BIT_NS       = CLKS_PER_BIT * 20;
   localparam int MAX_BYTES    = 64;
   // tx loses one bit in eleven, backlog hits FIFO_DEPTH + TX_CREDITS near frame 55
   localparam int OVERRUN_BYTES = 64;
   localparam int IDLE_LIMIT    = 24 * CLKS_PER_BIT;
   localparam int TOTAL_FRAMES  = (TX_STOP_BITS == 1) ? 34 : OVERRUN_BYTES;
   localparam int WATCHDOG_NS   = TOTAL_FRAMES * (11 + TX_STOP_BITS) * BIT_NS * 3;

   typedef byte_t byte_list_t [MAX_BYTES];
   typedef logic mark_list_t [MAX_BYTES];

   typedef struct packed {
      logic overrun;
      logic frame_error;
   } flags_t;

   logic       clk;
   logic       rst_n;
   logic       rx;
   logic       tx;
   logic       overrun;
   logic       frame_error;
   byte_list_t sent_bytes;
   mark_list_t sent_bad;
   int         n_sent;
   byte_list_t exp_bytes;
   flags_t     exp_flags;
   int         n_exp;
   byte_list_t recv_bytes;
   int         n_recv;

   uart_echo_top #(
      .CLKS_PER_BIT(CLKS_PER_BIT),
      .TX_STOP_BITS(TX_STOP_BITS),
      .FIFO_DEPTH  (FIFO_DEPTH)
   ) u_uart_echo_top (
      .clk        (clk),
      .rst_n      (rst_n),
      .rx         (rx),
      .tx         (tx),
      .overrun    (overrun),
      .frame_error(frame_error)
   );

   serial_host #(
      .CLKS_PER_BIT(CLKS_PER_BIT)
   ) u_host (
      .clk(clk),
      .tx (tx),
      .rx (rx)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired before the tests completed");
      $display("Finished with errors");
      $fatal(1, "timeout");
   end

   task automatic next_cycles(input int n);
      repeat (n) begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         $display("MISMATCH %s: actual 0x%h, expected 0x%h", name, actual, expected);
         $display("Finished with errors");
         $fatal(1, "stopped at first error");
      end
   endtask

   // good bytes in order; with a slower tx only the first capacity bytes are sure
   function automatic int expected_echo(input byte_list_t sent, input mark_list_t bad,
                                        input int n, input int fifo_depth,
                                        input int tx_credits, input int rx_frame_bits,
                                        input int tx_frame_bits, output byte_list_t echo,
                                        output flags_t flags);
      int n_good;
      int capacity;
      int i;
      n_good   = 0;
      flags    = '0;
      capacity = fifo_depth + tx_credits;
      for (i = 0; i < n; i++) begin
         if (bad[i]) begin
            flags.frame_error = 1'b1;
         end else begin
            echo[n_good] = sent[i];
            n_good++;
         end
      end
      // backlog starts at one frame and grows by one per tx_frame_bits/(tx-rx) frames
      if (tx_frame_bits > rx_frame_bits &&
          (n_good - 1) * (tx_frame_bits - rx_frame_bits) >= (capacity - 1) * tx_frame_bits) begin
         flags.overrun = 1'b1;
         return capacity;
      end
      return n_good;
   endfunction

   task automatic apply_reset();
      @(posedge clk);
      #1;
      rst_n = 1'b0;
      next_cycles(5);
      rst_n = 1'b1;
   endtask

   task automatic load_random(input int n);
      int i;
      for (i = 0; i < n; i++) begin
         sent_bytes[i] = byte_t'($urandom);
         sent_bad[i]   = 1'b0;
      end
      n_sent = n;
   endtask

   task automatic collect_and_compare();
      byte_t data;
      logic  start_bit;
      logic  stop_bit;
      logic  got;
      int    pos;
      int    matched;
      int    i;
      n_recv = 0;
      got    = 1'b1;
      while (got) begin
         u_host.receive_byte(data, start_bit, stop_bit, got, IDLE_LIMIT);
         if (got) begin
            check_value("tx_start_bit", 32'(start_bit), 32'd0);
            check_value("tx_stop_bit", 32'(stop_bit), 32'd1);
            if (n_recv < n_exp) begin
               check_value("echo_byte", 32'(data), 32'(exp_bytes[n_recv]));
            end
            if (n_recv < MAX_BYTES) begin
               recv_bytes[n_recv] = data;
            end
            n_recv++;
         end
      end
      if (exp_flags.overrun) begin
         check_value("echo_count_min", 32'(n_recv >= n_exp), 32'd1);
      end else begin
         check_value("echo_count", 32'(n_recv), 32'(n_exp));
      end
      // echoed bytes must form a subsequence of what was sent
      pos     = 0;
      matched = 0;
      for (i = 0; i < n_recv && i < MAX_BYTES; i++) begin
         while (pos < n_sent && sent_bytes[pos] != recv_bytes[i]) begin
            pos++;
         end
         if (pos < n_sent) begin
            matched++;
            pos++;
         end
      end
      check_value("echo_order", 32'(matched), 32'(n_recv));
   endtask

   task automatic run_echo_test(input int gap_bits);
      int i;
      apply_reset();
      n_exp = expected_echo(sent_bytes, sent_bad, n_sent, FIFO_DEPTH, TX_CREDITS,
                            10 + gap_bits, 9 + TX_STOP_BITS, exp_bytes, exp_flags);
      fork
         begin
            for (i = 0; i < n_sent; i++) begin
               u_host.send_byte(sent_bytes[i], !sent_bad[i], gap_bits);
            end
         end
         collect_and_compare();
      join
      check_value("frame_error", 32'(frame_error), 32'(exp_flags.frame_error));
      check_value("overrun", 32'(overrun), 32'(exp_flags.overrun));
   endtask

   task automatic run_idle_test();
      apply_reset();
      repeat (20 * CLKS_PER_BIT) begin
         next_cycles(1);
         check_value("tx", 32'(tx), 32'd1);
         check_value("overrun", 32'(overrun), 32'd0);
         check_value("frame_error", 32'(frame_error), 32'd0);
      end
   endtask

   initial begin
      string greeting;
      int    i;
      void'($urandom(32'hfd77));
      rst_n       = 1'b0;
      n_sent      = 0;
      greeting    = "HELLO RS232";
      if (TX_STOP_BITS == 1) begin
         for (i = 0; i < greeting.len(); i++) begin
            sent_bytes[i] = byte_t'(greeting[i]);
            sent_bad[i]   = 1'b0;
         end
         n_sent = greeting.len();
         run_echo_test(2);
         load_random(20);
         run_echo_test(0);
         // middle frame carries a low stop bit
         load_random(3);
         sent_bad[1] = 1'b1;
         run_echo_test(2);
         run_idle_test();
      end else begin
         load_random(OVERRUN_BYTES);
         run_echo_test(0);
      end
      $display("Finished with no errors");
      $finish;
   end

endmodule

// File: project.f
source/uart_pkg.sv
source/uart_rx.sv
source/echo_buffer.sv
source/uart_tx.sv
source/uart_echo_top.sv
testbench/serial_host.sv
testbench/tb_uart_echo.sv

// File: run.sh
#!/bin/sh
# builds and runs the testbench once per transmitter stop-bit setting
set -e
cd "$(dirname "$0")"
rm -f sim.log

for stop in 1 2; do
   verilator --binary --timing --assert -Wno-fatal -f project.f \
      --top-module tb_uart_echo -GTX_STOP_BITS=$stop -Mdir build/stop$stop -o sim
   ./build/stop$stop/sim >> sim.log 2>&1 || true
done

cat sim.log
if grep -q "Finished with errors" sim.log; then
   exit 1
fi
if [ "$(grep -c "Finished with no errors" sim.log)" -ne 2 ]; then
   echo "simulation did not complete both runs"
   exit 1
fi
